//--- verilog.f
bnn_pkg.sv
bnn_regmap_pkg.sv
bnn_axil_slave.sv
bnn_param_store.sv
bnn_sequencer.sv
neuron_counter.sv
hidden_neuron_unit.sv
class_scorer.sv
bnn_classifier_top.sv
bnn_properties.sv
tb_bnn_classifier.sv

//--- tb_bnn_classifier.sv
`timescale 1ns/100ps

module tb_bnn_classifier;
    import bnn_pkg::*;
    import bnn_regmap_pkg::*;

    localparam int HIDDEN_CNT    = DEF_HIDDEN_CNT;
    localparam int CLASS_CNT     = DEF_CLASS_CNT;
    localparam int LOAD_ACC      = FEAT_WORDS + 2*CLASS_CNT + 2*HIDDEN_CNT;
    localparam int RUN_CNT       = 27; // readback, 20 random, tie, latency, busy, unmapped.
    localparam int ACCESS_CYCLES = 5;
    localparam int WATCHDOG_CYCLES = RUN_CNT*(LOAD_ACC*ACCESS_CYCLES + 60) + 2000;

    logic  clk = 1'b0;
    logic  reset;
    addr_t awaddr, araddr;
    data_t wdata, rdata;
    resp_t bresp, rresp;
    logic  awvalid, awready, wvalid, wready, bvalid, bready;
    logic  arvalid, arready, rvalid, rready;

    int seed = 67;
    int checks = 0;
    int errors = 0;
    int cycle_cnt = 0;
    int hs_edge, rd_edge;

    // reference copy of the loaded model.
    logic [FEAT_BITS-1:0]  feat_m [FEAT_CNT];
    logic [FEAT_CNT-1:0]   add_m  [HIDDEN_CNT];
    logic [FEAT_CNT-1:0]   sub_m  [HIDDEN_CNT];
    logic                  pol_m  [HIDDEN_CNT];
    logic [HIDDEN_CNT-1:0] cw_m   [CLASS_CNT];

    bnn_classifier_top dut0 (
        .clk, .reset,
        .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready
    );

    bind bnn_classifier_top bnn_properties u_props (
        .clk(clk), .reset(reset),
        .awready(awready), .wready(wready), .arready(arready),
        .bvalid(bvalid), .bready(bready), .bresp(bresp),
        .rvalid(rvalid), .rready(rready), .rdata(rdata),
        .busy(busy), .done(done), .prediction(prediction)
    );

    always #10 clk = ~clk;

    always @(posedge clk)
        cycle_cnt <= cycle_cnt + 1; // rising edge count for the latency checks.

    task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("Fail %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic axil_write(input addr_t addr, input data_t data, input resp_t exp);
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b0; // response waits one cycle.
        @(negedge clk);
        while (!awready)
            @(negedge clk);
        compare(32'(wready), 32'h1, "wready together with awready");
        hs_edge = cycle_cnt + 1; // accepted at the next rising edge.
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid)
            @(negedge clk);
        @(negedge clk);
        bready = 1'b1;
        compare(32'(bresp), 32'(exp), $sformatf("write response at %h", addr));
    endtask

    task automatic axil_read(input addr_t addr, input resp_t exp, output data_t data);
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b0;
        @(negedge clk);
        while (!arready)
            @(negedge clk);
        rd_edge = cycle_cnt + 1;
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid)
            @(negedge clk);
        @(negedge clk);
        rready = 1'b1;
        data = rdata;
        compare(32'(rresp), 32'(exp), $sformatf("read response at %h", addr));
    endtask

    task automatic randomize_model();
        logic [31:0] rnd;
        for (int f = 0; f < FEAT_CNT; f++) begin
            rnd = $random(seed);
            feat_m[f] = rnd[FEAT_BITS-1:0];
        end
        for (int n = 0; n < HIDDEN_CNT; n++) begin
            rnd = $random(seed);
            add_m[n] = rnd[FEAT_CNT-1:0];
            pol_m[n] = rnd[31];
            rnd = $random(seed);
            sub_m[n] = rnd[FEAT_CNT-1:0];
        end
        for (int c = 0; c < CLASS_CNT; c++)
            cw_m[c] = HIDDEN_CNT'({$random(seed), $random(seed)});
    endtask

    // address of model register i in load order.
    function automatic addr_t model_addr(input int i);
        if (i < FEAT_WORDS)
            return addr_t'(FEAT_OFS + 4*i);
        else if (i < FEAT_WORDS + 2*CLASS_CNT)
            return addr_t'(CLASSW_OFS + 4*(i - FEAT_WORDS));
        else
            return addr_t'(HADD_OFS + 4*(i - FEAT_WORDS - 2*CLASS_CNT));
    endfunction

    function automatic data_t model_word(input int i);
        data_t d;
        int    j;
        int    n;
        d = '0;
        if (i < FEAT_WORDS) begin
            for (int k = 0; k < 8; k++)
                if (8*i + k < FEAT_CNT)
                    d[4*k +: 4] = feat_m[8*i + k];
        end else if (i < FEAT_WORDS + 2*CLASS_CNT) begin
            j = i - FEAT_WORDS;
            for (int b = 0; b < 32; b++)
                if (32*(j % 2) + b < HIDDEN_CNT)
                    d[b] = cw_m[j / 2][32*(j % 2) + b];
        end else begin
            j = i - FEAT_WORDS - 2*CLASS_CNT;
            n = j / 2;
            if (j % 2 == 1)
                d[FEAT_CNT-1:0] = sub_m[n];
            else
                d = {pol_m[n], 12'b0, add_m[n]};
        end
        return d;
    endfunction

    task automatic load_model();
        for (int i = 0; i < LOAD_ACC; i++)
            axil_write(model_addr(i), model_word(i), RESP_OKAY);
    endtask

    function automatic logic [HIDDEN_CNT-1:0] ref_hidden();
        logic [HIDDEN_CNT-1:0] h;
        int                    sum;
        for (int n = 0; n < HIDDEN_CNT; n++) begin
            sum = 0;
            for (int f = 0; f < FEAT_CNT; f++) begin
                if (add_m[n][f])
                    sum = sum + int'(feat_m[f]);
                if (sub_m[n][f])
                    sum = sum - int'(feat_m[f]);
            end
            h[n] = pol_m[n] ? (sum >= 0) : (sum < 0);
        end
        return h;
    endfunction

    // xnor-popcount argmax where the lowest class wins a tie.
    function automatic int ref_predict();
        logic [HIDDEN_CNT-1:0] h;
        int                    best;
        int                    best_c;
        int                    s;
        h      = ref_hidden();
        best   = -1;
        best_c = 0;
        for (int c = 0; c < CLASS_CNT; c++) begin
            s = 0;
            for (int n = 0; n < HIDDEN_CNT; n++)
                if (h[n] == cw_m[c][n])
                    s++;
            if (s > best) begin
                best   = s;
                best_c = c;
            end
        end
        return best_c;
    endfunction

    task automatic wait_done(output data_t status);
        int polls;
        polls  = 0;
        status = '0;
        while (!status[1] && polls < 40) begin
            axil_read(STATUS_OFS, RESP_OKAY, status);
            polls++;
        end
        checks++;
        assert (status[1])
        else begin
            errors++;
            $display("Run did not report done after %0d status reads", polls);
        end
        compare(32'(status[1:0]), 32'h2, "busy and done at the end of a run");
    endtask

    task automatic run_and_compare(input int exp, input string what);
        data_t st;
        axil_write(CTRL_OFS, 32'h1, RESP_OKAY);
        wait_done(st);
        compare(32'(st[9:8]), exp, what);
    endtask

    task automatic verify_readback();
        data_t d;
        randomize_model();
        load_model();
        for (int i = 0; i < LOAD_ACC; i++) begin
            axil_read(model_addr(i), RESP_OKAY, d);
            compare(d, model_word(i), $sformatf("readback at %h", model_addr(i)));
        end
    endtask

    task automatic classify_random(input int runs);
        for (int r = 0; r < runs; r++) begin
            randomize_model();
            load_model();
            run_and_compare(ref_predict(), $sformatf("prediction of random model %0d", r));
        end
    endtask

    task automatic tie_rule();
        logic [HIDDEN_CNT-1:0] h;
        randomize_model();
        for (int c = 1; c < CLASS_CNT; c++)
            cw_m[c] = cw_m[0];
        load_model();
        run_and_compare(0, "prediction with identical class weights");
        h       = ref_hidden();
        cw_m[0] = ~h;
        cw_m[1] = ~h;
        cw_m[2] = h;
        load_model();
        run_and_compare(2, "prediction with class 2 matching the hidden vector");
    endtask

    // the read lands on edge T+cap_ofs and shows the state of the edge before.
    task automatic measure_latency(input int cap_ofs);
        data_t st;
        int    t0;
        axil_write(CTRL_OFS, 32'h1, RESP_OKAY);
        t0 = hs_edge;
        axil_read(STATUS_OFS, RESP_OKAY, st);
        compare(32'(st[1:0]), 32'h1, "status early in the run");
        while (cycle_cnt < t0 + cap_ofs - 3)
            @(negedge clk);
        axil_read(STATUS_OFS, RESP_OKAY, st);
        compare(rd_edge, t0 + cap_ofs, "status sample edge");
        compare(32'(st[1:0]), (cap_ofs >= HIDDEN_CNT + 3) ? 32'h2 : 32'h1,
                $sformatf("status sampled %0d edges after start", cap_ofs));
        wait_done(st);
    endtask

    task automatic busy_protection();
        data_t st;
        data_t d;
        int    exp;
        addr_t last_sub;
        last_sub = addr_t'(HSUB_OFS + 8*(HIDDEN_CNT-1)); // last neuron, evaluated late.
        randomize_model();
        load_model();
        exp = ref_predict();
        axil_write(CTRL_OFS, 32'h1, RESP_OKAY);
        axil_write(FEAT_OFS, ~model_word(0), RESP_SLVERR);
        axil_write(CLASSW_OFS, ~model_word(FEAT_WORDS), RESP_SLVERR);
        axil_write(last_sub, ~model_word(LOAD_ACC - 1), RESP_SLVERR);
        axil_write(CTRL_OFS, 32'h1, RESP_SLVERR);
        axil_write(STATUS_OFS, 32'h0, RESP_OKAY); // read-only register.
        wait_done(st);
        compare(32'(st[9:8]), exp, "prediction after writes during a run");
        axil_read(FEAT_OFS, RESP_OKAY, d);
        compare(d, model_word(0), "feature word after a blocked write");
        axil_read(CLASSW_OFS, RESP_OKAY, d);
        compare(d, model_word(FEAT_WORDS), "class weight word after a blocked write");
        axil_read(last_sub, RESP_OKAY, d);
        compare(d, model_word(LOAD_ACC - 1), "subtract mask after a blocked write");
    endtask

    task automatic unmapped_access();
        addr_t bad [6];
        data_t d;
        bad[0] = 10'h008;
        bad[1] = 10'h020;
        bad[2] = addr_t'(CLASSW_OFS + 8*CLASS_CNT);
        bad[3] = addr_t'(HADD_OFS + 8*HIDDEN_CNT);
        bad[4] = 10'h012;
        bad[5] = 10'h3fc;
        for (int i = 0; i < 6; i++) begin
            axil_read(bad[i], RESP_SLVERR, d);
            compare(d, 32'h0, $sformatf("read data at unmapped %h", bad[i]));
            axil_write(bad[i], 32'ha5a5_a5a5, RESP_SLVERR);
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout, the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Something failed");
        $finish;
    end

    initial begin
        data_t st;
        reset   = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        axil_read(STATUS_OFS, RESP_OKAY, st);
        compare(st, 32'h0, "status after reset");
        verify_readback();
        classify_random(20);
        tie_rule();
        measure_latency(HIDDEN_CNT + 2);
        measure_latency(HIDDEN_CNT + 3);
        busy_protection();
        unmapped_access();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

//--- bnn_properties.sv
`timescale 1ns/100ps

module bnn_properties (
    input logic                  clk,
    input logic                  reset,
    input logic                  awready,
    input logic                  wready,
    input logic                  arready,
    input logic                  bvalid,
    input logic                  bready,
    input bnn_regmap_pkg::resp_t bresp,
    input logic                  rvalid,
    input logic                  rready,
    input bnn_regmap_pkg::data_t rdata,
    input logic                  busy,
    input logic                  done,
    input bnn_pkg::class_idx_t   prediction
);

    // write response held until taken.
    bresp_held: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("bvalid or bresp changed before bready");

    rdata_held: assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("rvalid or rdata changed before rready");

    busy_done_excl: assert property (@(posedge clk) disable iff (reset)
        !(busy && done))
        else $error("busy and done high together");

    reset_state: assert property (@(posedge clk)
        reset |=> !awready && !wready && !arready && !bvalid && !rvalid
                  && !busy && !done && (prediction == '0))
        else $error("control outputs not cleared by reset");

endmodule

//--- bnn_classifier_top.sv
`timescale 1ns/100ps

module bnn_classifier_top #(
    parameter int HIDDEN_CNT = bnn_pkg::DEF_HIDDEN_CNT,
    parameter int CLASS_CNT  = bnn_pkg::DEF_CLASS_CNT
) (
    input  logic                  clk,
    input  logic                  reset,
    input  bnn_regmap_pkg::addr_t awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  bnn_regmap_pkg::data_t wdata,
    input  logic                  wvalid,
    output logic                  wready,
    output bnn_regmap_pkg::resp_t bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  bnn_regmap_pkg::addr_t araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output bnn_regmap_pkg::data_t rdata,
    output bnn_regmap_pkg::resp_t rresp,
    output logic                  rvalid,
    input  logic                  rready
);
    import bnn_pkg::*;
    import bnn_regmap_pkg::*;

    logic        reg_we, store_hit, start;
    addr_t       reg_addr, read_addr;
    data_t       reg_wdata, store_rdata;
    logic        busy, done;
    logic        count_clear, count_en, hidden_en, score_en;
    logic        last_neuron, polarity;
    neuron_idx_t neuron_idx;
    class_idx_t  prediction;
    feat_vec_t   features;
    feat_mask_t  add_mask, sub_mask;

    logic [CLASS_CNT*HIDDEN_CNT-1:0] class_weights;
    logic [HIDDEN_CNT-1:0]           hidden;

    bnn_axil_slave u_slave (
        .clk, .reset,
        .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .busy, .done, .prediction, .store_rdata, .store_hit,
        .reg_we, .reg_addr, .reg_wdata, .read_addr, .start
    );

    bnn_param_store #(.HIDDEN_CNT(HIDDEN_CNT), .CLASS_CNT(CLASS_CNT)) u_store (
        .clk, .reset, .reg_we, .reg_addr, .reg_wdata, .read_addr, .neuron_idx,
        .store_rdata, .store_hit, .features, .add_mask, .sub_mask, .polarity,
        .class_weights
    );

    bnn_sequencer u_seq (
        .clk, .reset, .start, .last_neuron,
        .busy, .done, .count_clear, .count_en, .hidden_en, .score_en
    );

    neuron_counter #(.HIDDEN_CNT(HIDDEN_CNT)) u_count (
        .clk, .reset, .count_clear, .count_en, .neuron_idx, .last_neuron
    );

    hidden_neuron_unit #(.HIDDEN_CNT(HIDDEN_CNT)) u_hidden (
        .clk, .reset, .hidden_en, .neuron_idx, .features,
        .add_mask, .sub_mask, .polarity, .hidden
    );

    class_scorer #(.HIDDEN_CNT(HIDDEN_CNT), .CLASS_CNT(CLASS_CNT)) u_scorer (
        .clk, .reset, .score_en, .hidden, .class_weights, .prediction
    );

endmodule

//--- class_scorer.sv
`timescale 1ns/100ps

module class_scorer #(
    parameter int HIDDEN_CNT = bnn_pkg::DEF_HIDDEN_CNT,
    parameter int CLASS_CNT  = bnn_pkg::DEF_CLASS_CNT
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            score_en,
    input  logic [HIDDEN_CNT-1:0]           hidden,
    input  logic [CLASS_CNT*HIDDEN_CNT-1:0] class_weights,
    output bnn_pkg::class_idx_t             prediction
);
    import bnn_pkg::*;

    score_t     score [CLASS_CNT];
    score_t     best;
    class_idx_t best_idx;

    // xnor-popcount, one score per class.
    always_comb begin
        for (int c = 0; c < CLASS_CNT; c++) begin
            score[c] = '0;
            for (int h = 0; h < HIDDEN_CNT; h++)
                score[c] = score[c] + score_t'(hidden[h] ~^ class_weights[c*HIDDEN_CNT + h]);
        end
    end

    // strict compare keeps the lowest index on a tie.
    always_comb begin
        best     = score[0];
        best_idx = '0;
        for (int c = 1; c < CLASS_CNT; c++) begin
            if (score[c] > best) begin
                best     = score[c];
                best_idx = class_idx_t'(c);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            prediction <= '0;
        else if (score_en)
            prediction <= best_idx;
    end

endmodule

//--- hidden_neuron_unit.sv
`timescale 1ns/100ps

module hidden_neuron_unit #(
    parameter int HIDDEN_CNT = bnn_pkg::DEF_HIDDEN_CNT
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  hidden_en,
    input  bnn_pkg::neuron_idx_t  neuron_idx,
    input  bnn_pkg::feat_vec_t    features,
    input  bnn_pkg::feat_mask_t   add_mask,
    input  bnn_pkg::feat_mask_t   sub_mask,
    input  logic                  polarity,
    output logic [HIDDEN_CNT-1:0] hidden
);
    import bnn_pkg::*;

    acc_t     sum;
    feature_t feat;
    logic     hid_bit;

    // ternary weights, both mask bits set cancel out.
    always_comb begin
        sum  = '0;
        feat = '0;
        for (int f = 0; f < FEAT_CNT; f++) begin
            feat = features[f*FEAT_BITS +: FEAT_BITS];
            if (add_mask[f])
                sum = sum + acc_t'({1'b0, feat});
            if (sub_mask[f])
                sum = sum - acc_t'({1'b0, feat});
        end
    end

    // sign threshold, polarity picks which side fires.
    assign hid_bit = polarity ? (sum >= 0) : (sum < 0);

    always_ff @(posedge clk) begin
        if (reset)
            hidden <= '0;
        else if (hidden_en)
            hidden[neuron_idx] <= hid_bit;
    end

endmodule

//--- neuron_counter.sv
`timescale 1ns/100ps

module neuron_counter #(
    parameter int HIDDEN_CNT = bnn_pkg::DEF_HIDDEN_CNT
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 count_clear,
    input  logic                 count_en,
    output bnn_pkg::neuron_idx_t neuron_idx,
    output logic                 last_neuron
);
    import bnn_pkg::*;

    assign last_neuron = (neuron_idx == neuron_idx_t'(HIDDEN_CNT - 1));

    always_ff @(posedge clk) begin
        if (reset)
            neuron_idx <= '0;
        else if (count_clear)
            neuron_idx <= '0;
        else if (count_en)
            neuron_idx <= last_neuron ? '0 : neuron_idx + 1'b1; // wrap after the last.
    end

endmodule

//--- bnn_sequencer.sv
`timescale 1ns/100ps

module bnn_sequencer (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic last_neuron,
    output logic busy,
    output logic done,
    output logic count_clear,
    output logic count_en,
    output logic hidden_en,
    output logic score_en
);
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HIDDEN,
        ST_SCORE,
        ST_FINISH
    } state_t;

    state_t state, state_nxt;

    always_ff @(posedge clk) begin
        if (reset)
            state <= ST_IDLE;
        else
            state <= state_nxt;
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE, ST_FINISH: if (start) state_nxt = ST_HIDDEN;
            ST_HIDDEN:          if (last_neuron) state_nxt = ST_SCORE;
            ST_SCORE:           state_nxt = ST_FINISH; // prediction lands here.
            default:            state_nxt = ST_IDLE;
        endcase
    end

    assign busy        = (state == ST_HIDDEN) || (state == ST_SCORE);
    assign done        = (state == ST_FINISH); // held until the next start.
    assign count_clear = start & ~busy;
    assign hidden_en   = (state == ST_HIDDEN); // one neuron per clock.
    assign count_en    = hidden_en;
    assign score_en    = (state == ST_SCORE);

endmodule

//--- bnn_param_store.sv
`timescale 1ns/100ps

module bnn_param_store #(
    parameter int HIDDEN_CNT = bnn_pkg::DEF_HIDDEN_CNT,
    parameter int CLASS_CNT  = bnn_pkg::DEF_CLASS_CNT
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          reg_we,
    input  bnn_regmap_pkg::addr_t         reg_addr,
    input  bnn_regmap_pkg::data_t         reg_wdata,
    input  bnn_regmap_pkg::addr_t         read_addr,
    input  bnn_pkg::neuron_idx_t          neuron_idx,
    output bnn_regmap_pkg::data_t         store_rdata,
    output logic                          store_hit,
    output bnn_pkg::feat_vec_t            features,
    output bnn_pkg::feat_mask_t           add_mask,
    output bnn_pkg::feat_mask_t           sub_mask,
    output logic                          polarity,
    output logic [CLASS_CNT*HIDDEN_CNT-1:0] class_weights
);
    import bnn_pkg::*;
    import bnn_regmap_pkg::*;

    localparam int FEAT_PER_WORD = 32 / FEAT_BITS;

    feat_vec_t             feat_q;
    feat_mask_t            add_q [HIDDEN_CNT];
    feat_mask_t            sub_q [HIDDEN_CNT];
    logic [HIDDEN_CNT-1:0] pol_q;
    logic [HIDDEN_CNT-1:0] cw_q [CLASS_CNT];

    logic        wr_feat, wr_cw, wr_hid;
    logic        rd_feat, rd_cw, rd_hid;
    int unsigned wr_idx, rd_idx;

    // idx is the word offset from the start of the matching block.
    function automatic void decode(input addr_t a, output logic is_feat, output logic is_cw,
                                   output logic is_hid, output int unsigned idx);
        is_feat = 1'b0;
        is_cw   = 1'b0;
        is_hid  = 1'b0;
        idx     = 0;
        if (a[1:0] == 2'b00) begin
            if (a >= FEAT_OFS && a < FEAT_OFS + 4*FEAT_WORDS) begin
                is_feat = 1'b1;
                idx     = (a - FEAT_OFS) >> 2;
            end else if (a >= CLASSW_OFS && a < CLASSW_OFS + 8*CLASS_CNT) begin
                is_cw = 1'b1;
                idx   = (a - CLASSW_OFS) >> 2;
            end else if (a >= HADD_OFS && a <= HSUB_OFS + 8*(HIDDEN_CNT-1)) begin
                is_hid = 1'b1;
                idx    = (a - HADD_OFS) >> 2;
            end
        end
    endfunction

    always_comb decode(reg_addr, wr_feat, wr_cw, wr_hid, wr_idx);
    always_comb decode(read_addr, rd_feat, rd_cw, rd_hid, rd_idx);

    assign store_hit = rd_feat | rd_cw | rd_hid;

    always_ff @(posedge clk) begin
        if (reset) begin
            feat_q <= '0;
            pol_q  <= '0;
            for (int n = 0; n < HIDDEN_CNT; n++) begin
                add_q[n] <= '0;
                sub_q[n] <= '0;
            end
            for (int c = 0; c < CLASS_CNT; c++)
                cw_q[c] <= '0;
        end else if (reg_we) begin
            if (wr_feat) begin
                for (int f = 0; f < FEAT_PER_WORD; f++)
                    if (wr_idx*FEAT_PER_WORD + f < FEAT_CNT)
                        feat_q[(wr_idx*FEAT_PER_WORD + f)*FEAT_BITS +: FEAT_BITS] <=
                            reg_wdata[f*FEAT_BITS +: FEAT_BITS];
            end else if (wr_cw) begin
                for (int b = 0; b < 32; b++)
                    if (32*wr_idx[0] + b < HIDDEN_CNT)
                        cw_q[wr_idx >> 1][32*wr_idx[0] + b] <= reg_wdata[b];
            end else if (wr_hid) begin
                if (wr_idx[0])
                    sub_q[wr_idx >> 1] <= reg_wdata[FEAT_CNT-1:0];
                else begin
                    add_q[wr_idx >> 1] <= reg_wdata[FEAT_CNT-1:0];
                    pol_q[wr_idx >> 1] <= reg_wdata[31];
                end
            end
        end
    end

    always_comb begin
        store_rdata = '0;
        if (rd_feat) begin
            for (int f = 0; f < FEAT_PER_WORD; f++)
                if (rd_idx*FEAT_PER_WORD + f < FEAT_CNT)
                    store_rdata[f*FEAT_BITS +: FEAT_BITS] =
                        feat_q[(rd_idx*FEAT_PER_WORD + f)*FEAT_BITS +: FEAT_BITS];
        end else if (rd_cw) begin
            for (int b = 0; b < 32; b++)
                if (32*rd_idx[0] + b < HIDDEN_CNT)
                    store_rdata[b] = cw_q[rd_idx >> 1][32*rd_idx[0] + b];
        end else if (rd_hid) begin
            if (rd_idx[0])
                store_rdata = {13'b0, sub_q[rd_idx >> 1]};
            else
                store_rdata = {pol_q[rd_idx >> 1], 12'b0, add_q[rd_idx >> 1]};
        end
    end

    // neuron read port for the hidden layer.
    assign features = feat_q;
    assign add_mask = add_q[neuron_idx];
    assign sub_mask = sub_q[neuron_idx];
    assign polarity = pol_q[neuron_idx];

    always_comb begin
        for (int c = 0; c < CLASS_CNT; c++)
            class_weights[c*HIDDEN_CNT +: HIDDEN_CNT] = cw_q[c];
    end

endmodule

//--- bnn_axil_slave.sv
`timescale 1ns/100ps

module bnn_axil_slave (
    input  logic                  clk,
    input  logic                  reset,
    input  bnn_regmap_pkg::addr_t awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  bnn_regmap_pkg::data_t wdata,
    input  logic                  wvalid,
    output logic                  wready,
    output bnn_regmap_pkg::resp_t bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  bnn_regmap_pkg::addr_t araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output bnn_regmap_pkg::data_t rdata,
    output bnn_regmap_pkg::resp_t rresp,
    output logic                  rvalid,
    input  logic                  rready,
    input  logic                  busy,
    input  logic                  done,
    input  bnn_pkg::class_idx_t   prediction,
    input  bnn_regmap_pkg::data_t store_rdata,
    input  logic                  store_hit,
    output logic                  reg_we,
    output bnn_regmap_pkg::addr_t reg_addr,
    output bnn_regmap_pkg::data_t reg_wdata,
    output bnn_regmap_pkg::addr_t read_addr,
    output logic                  start
);
    import bnn_regmap_pkg::*;

    logic  aw_go, ar_go;
    logic  wr_acc, rd_acc;
    logic  ctrl_wr, status_wr;
    resp_t wr_resp, rd_resp;
    data_t rd_data, status_word;

    // a write wins when both channels ask in the same cycle.
    assign aw_go  = awvalid & wvalid & ~awready & ~bvalid;
    assign ar_go  = arvalid & ~arready & ~rvalid & ~aw_go;
    assign wr_acc = awready & awvalid & wvalid;
    assign rd_acc = arready & arvalid;

    // the store decodes one address at a time.
    assign read_addr = awready ? awaddr : araddr;
    assign reg_addr  = awaddr;
    assign reg_wdata = wdata;
    assign reg_we    = wr_acc & store_hit & ~busy; // no updates during a run.

    assign ctrl_wr     = (awaddr == CTRL_OFS);
    assign status_wr   = (awaddr == STATUS_OFS);
    assign status_word = {22'b0, prediction, 6'b0, done, busy};

    always_comb begin
        if (ctrl_wr)
            wr_resp = (wdata[0] && busy) ? RESP_SLVERR : RESP_OKAY;
        else if (status_wr)
            wr_resp = RESP_OKAY; // read-only, write dropped.
        else if (store_hit)
            wr_resp = busy ? RESP_SLVERR : RESP_OKAY;
        else
            wr_resp = RESP_SLVERR;
    end

    always_comb begin
        rd_resp = RESP_OKAY;
        rd_data = '0;
        if (araddr == STATUS_OFS)
            rd_data = status_word;
        else if (araddr != CTRL_OFS) begin
            if (store_hit)
                rd_data = store_rdata;
            else
                rd_resp = RESP_SLVERR;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
            start   <= 1'b0;
        end else begin
            awready <= aw_go;
            wready  <= aw_go;
            arready <= ar_go;
            start   <= wr_acc & ctrl_wr & wdata[0] & ~busy; // one cycle pulse.
            if (wr_acc)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;
            if (rd_acc)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    // response payload, held until the master takes it.
    always_ff @(posedge clk) begin
        if (wr_acc)
            bresp <= wr_resp;
        if (rd_acc) begin
            rdata <= rd_data;
            rresp <= rd_resp;
        end
    end

endmodule

//--- bnn_regmap_pkg.sv
package bnn_regmap_pkg;

    typedef logic [9:0]  addr_t;
    typedef logic [31:0] data_t;
    typedef logic [1:0]  resp_t;

    parameter resp_t RESP_OKAY   = 2'b00;
    parameter resp_t RESP_SLVERR = 2'b10;

    // control and status.
    parameter addr_t CTRL_OFS   = 10'h000; // bit 0 starts a run.
    parameter addr_t STATUS_OFS = 10'h004; // busy, done, prediction.

    // features, 8 per word, low feature first.
    parameter addr_t FEAT_OFS   = 10'h010;
    parameter int    FEAT_WORDS = 3;

    // class c weights at 8c, neurons 0-31 low word, rest high word.
    parameter addr_t CLASSW_OFS = 10'h040;

    // hidden neuron n at 8n: add mask plus polarity, then subtract mask.
    parameter addr_t HADD_OFS = 10'h100;
    parameter addr_t HSUB_OFS = 10'h104;

endpackage

//--- bnn_pkg.sv
package bnn_pkg;

    // fixed by the register map.
    parameter int FEAT_CNT  = 19;
    parameter int FEAT_BITS = 4;

    // defaults for the top level.
    parameter int DEF_HIDDEN_CNT = 40;
    parameter int DEF_CLASS_CNT  = 3;

    // one unsigned input feature.
    typedef logic [FEAT_BITS-1:0] feature_t;

    // feature f sits in bits 4f and up.
    typedef logic [FEAT_CNT*FEAT_BITS-1:0] feat_vec_t;

    // one add or subtract mask, one bit per feature.
    typedef logic [FEAT_CNT-1:0] feat_mask_t;

    // hidden neuron sum, range is +/-285.
    typedef logic signed [9:0] acc_t;

    typedef logic [5:0] neuron_idx_t; // up to 64 neurons.
    typedef logic [1:0] class_idx_t;  // up to 4 classes.

    // popcount of matching hidden bits.
    typedef logic [6:0] score_t;

endpackage
